// ==== all.f ====
+incdir+hdl
hdl/ps2_pkg.sv
hdl/ps2_line_sync.sv
hdl/ps2_frame_rx.sv
hdl/ps2_frame_tx.sv
hdl/ps2_mouse_ctrl.sv
hdl/ps2_packet_asm.sv
hdl/ps2_mouse_top.sv
dv/ps2_mouse_chk.sv
dv/ps2_mouse_tb.sv

// ==== Makefile ====
# PS/2 mouse host interface, Verilator lint and simulation

TOP = ps2_mouse_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/ps2_mouse_tb.sv ====
// PS/2 mouse host testbench
// behavioural mouse on open-drain lines, consumer with credit return,
// directed tests for init, restart, decode, errors and credit flow

`include "ps2_config.svh"

module ps2_mouse_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// device clock half period, in system clocks
	localparam int HALF = 40;
	// counters polled by the wait task
	localparam int CNT_PKT = 0;
	localparam int CNT_ERR = 1;
	localparam int CNT_DROP = 2;

	logic clk;
	logic reset;
	logic packet_credit = 1'b0;
	logic packet_valid;
	logic left;
	logic right;
	logic middle;
	logic [8:0] dx;
	logic [8:0] dy;
	logic streaming;
	logic frame_error;
	logic packet_drop;
	tri1 ps2_clk;
	tri1 ps2_data;

	// mouse side of the bus
	logic mouse_clk_low;
	logic mouse_data_low;
	logic [31:0] lfsr;
	int error_cnt = 0;
	int test_cnt = 0;
	int errs_at_start = 0;
	string test_name;
	// consumer side, filled on falling edges
	logic [20:0] pkt_q[$];
	int valid_cnt = 0;
	int frame_err_cnt = 0;
	int drop_cnt = 0;
	bit auto_credit = 1'b1;
	int credit_req = 0;

	// open drain, tri1 gives the idle high
	assign ps2_clk = mouse_clk_low ? 1'b0 : 1'bz;
	assign ps2_data = mouse_data_low ? 1'b0 : 1'bz;

	ps2_mouse_top i_ps2_mouse_top (
		.clk           (clk),
		.reset         (reset),
		.packet_credit (packet_credit),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.packet_valid  (packet_valid),
		.left          (left),
		.right         (right),
		.middle        (middle),
		.dx            (dx),
		.dy            (dy),
		.streaming     (streaming),
		.frame_error   (frame_error),
		.packet_drop   (packet_drop)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// consumer: capture packets and status pulses, hand back credits
	always @(negedge clk)
	begin
		if (packet_valid)
		begin
			pkt_q.push_back({left, right, middle, dx, dy});
			valid_cnt++;
		end
		if (frame_error)
			frame_err_cnt++;
		if (packet_drop)
			drop_cnt++;
		// takes each packet at once unless held back by a test
		if (auto_credit && packet_valid)
			packet_credit = 1'b1;
		else if (credit_req > 0)
		begin
			packet_credit = 1'b1;
			credit_req--;
		end
		else
			packet_credit = 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one lfsr step per bit
	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic random_packet(output logic [7:0] s, output logic [7:0] x,
		output logic [7:0] y);
		random_byte(s);
		// always_one bit of a status byte
		s[3] = 1'b1;
		random_byte(x);
		random_byte(y);
	endtask

	// buttons are status bits 0..2, x sign bit 4, y sign bit 5
	function automatic logic [20:0] expected_packet(input logic [7:0] s,
		input logic [7:0] x, input logic [7:0] y);
		return {s[0], s[1], s[2], s[4], x, s[5], y};
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Fail %s %s: expected %0h, actual %0h", test_name, what,
				expected, actual);
			error_cnt++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("%s: timed out waiting for %s", test_name, what);
		error_cnt++;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	function automatic int event_count(input int kind);
		case (kind)
			CNT_PKT: return valid_cnt;
			CNT_ERR: return frame_err_cnt;
			default: return drop_cnt;
		endcase
	endfunction

	// consumer counters change on falling edges, so poll on rising
	task automatic wait_count(input int kind, input int target, input string what);
		int n;
		n = 0;
		@(posedge clk);
		while (event_count(kind) < target && n < 2000)
		begin
			@(posedge clk);
			n++;
		end
		if (event_count(kind) < target)
			report_timeout(what);
	endtask

	task automatic wait_streaming();
		int n;
		n = 0;
		@(negedge clk);
		while (streaming !== 1'b1 && n < 1000)
		begin
			@(negedge clk);
			n++;
		end
		if (streaming !== 1'b1)
			report_timeout("streaming to rise");
	endtask

	task automatic check_packet(input string what, input logic [20:0] expected);
		if (pkt_q.size() == 0)
		begin
			$display("%s: no packet captured for %s", test_name, what);
			error_cnt++;
		end
		else
			check_value(what, 32'(expected), 32'(pkt_q.pop_front()));
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b0;
		mouse_clk_low = 1'b0;
		mouse_data_low = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// mouse model

	// device to host: start, data LSB first, parity, stop
	task automatic send_frame(input logic [7:0] b, input bit bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~(^b) ^ bad_parity, b, 1'b0};
		@(negedge clk);
		for (int i = 0; i < 11; i++)
		begin
			// data set up mid high phase, host samples on the fall
			mouse_data_low = ~bits[i];
			idle(HALF / 2);
			mouse_clk_low = 1'b1;
			idle(HALF);
			mouse_clk_low = 1'b0;
			idle(HALF / 2);
		end
		mouse_data_low = 1'b0;
		idle(HALF);
	endtask

	task automatic send_packet(input logic [7:0] s, input logic [7:0] x,
		input logic [7:0] y);
		send_frame(s, 1'b0);
		send_frame(x, 1'b0);
		send_frame(y, 1'b0);
	endtask

	// host to device frame, mouse generates the clock and acks
	task automatic receive_host_frame(output logic [7:0] cmd, output logic parity,
		output logic stop, output bit ok);
		logic [9:0] bits;
		int n;
		ok = 1'b0;
		n = 0;
		@(negedge clk);
		// request to send is clock released with data held low
		while (!(ps2_clk === 1'b1 && ps2_data === 1'b0) && n < 5000)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= 5000)
		begin
			report_timeout("host request to send");
			return;
		end
		idle(HALF);
		for (int i = 0; i < 10; i++)
		begin
			mouse_clk_low = 1'b1;
			idle(HALF);
			// host moves data while clock is low, read before the rise
			bits[i] = ps2_data;
			mouse_clk_low = 1'b0;
			idle(HALF);
		end
		// line ack, data low across the 11th clock
		mouse_data_low = 1'b1;
		idle(HALF / 2);
		mouse_clk_low = 1'b1;
		idle(HALF);
		mouse_clk_low = 1'b0;
		idle(HALF / 2);
		mouse_data_low = 1'b0;
		cmd = bits[7:0];
		parity = bits[8];
		stop = bits[9];
		ok = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests

	task automatic begin_test(input string name);
		test_name = name;
		errs_at_start = error_cnt;
	endtask

	task automatic end_test();
		test_cnt++;
		$display("%s: done, %0d errors", test_name, error_cnt - errs_at_start);
	endtask

	// checks one F4 frame from the host
	task automatic expect_stream_cmd(output bit ok);
		logic [7:0] cmd;
		logic parity;
		logic stop;
		receive_host_frame(cmd, parity, stop, ok);
		if (ok)
		begin
			check_value("command byte", 32'h0000_00f4, 32'(cmd));
			// data plus parity must hold an odd number of ones
			check_value("odd parity", 32'd1, 32'(^{parity, cmd}));
			check_value("stop bit", 32'd1, 32'(stop));
		end
	endtask

	task automatic test_init();
		bit ok;
		begin_test("init");
		apply_reset();
		expect_stream_cmd(ok);
		if (ok)
		begin
			check_value("streaming before reply", 32'd0, 32'(streaming));
			send_frame(8'hfa, 1'b0);
			wait_streaming();
		end
		end_test();
	endtask

	task automatic test_resend();
		bit ok;
		begin_test("wrong reply");
		apply_reset();
		expect_stream_cmd(ok);
		if (ok)
		begin
			send_frame(8'hfe, 1'b0);
			check_value("streaming after 0xfe", 32'd0, 32'(streaming));
			// restart shows up as a second command frame
			expect_stream_cmd(ok);
		end
		if (ok)
		begin
			check_value("streaming at restart", 32'd0, 32'(streaming));
			send_frame(8'hfa, 1'b0);
			wait_streaming();
		end
		end_test();
	endtask

	task automatic test_decode();
		logic [7:0] s;
		logic [7:0] x;
		logic [7:0] y;
		int base;
		begin_test("decode");
		for (int i = 0; i < 4; i++)
		begin
			random_packet(s, x, y);
			// packet comes out while the last frame is still winding down
			base = valid_cnt;
			send_packet(s, x, y);
			wait_count(CNT_PKT, base + 1, "decoded packet");
			check_packet("decoded packet", expected_packet(s, x, y));
		end
		end_test();
	endtask

	task automatic test_errors();
		logic [7:0] s;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] junk;
		int base_pkt;
		int base_err;
		begin_test("errors");
		@(posedge clk);
		base_pkt = valid_cnt;
		base_err = frame_err_cnt;
		// status, then x with bad parity
		random_packet(s, x, y);
		send_frame(s, 1'b0);
		send_frame(x, 1'b1);
		wait_count(CNT_ERR, base_err + 1, "frame_error");
		// not a status byte, dropped while hunting for byte 0
		random_byte(junk);
		junk[3] = 1'b0;
		send_frame(junk, 1'b0);
		random_packet(s, x, y);
		send_packet(s, x, y);
		wait_count(CNT_PKT, base_pkt + 1, "packet after errors");
		@(posedge clk);
		check_value("packet count", 32'(base_pkt + 1), 32'(valid_cnt));
		check_value("frame_error count", 32'(base_err + 1), 32'(frame_err_cnt));
		check_packet("packet after errors", expected_packet(s, x, y));
		end_test();
	endtask

	task automatic test_credits();
		logic [7:0] s[4];
		logic [7:0] x[4];
		logic [7:0] y[4];
		int base;
		int base_drop;
		begin_test("credits");
		@(posedge clk);
		auto_credit = 1'b0;
		base = valid_cnt;
		base_drop = drop_cnt;
		for (int i = 0; i < 4; i++)
			random_packet(s[i], x[i], y[i]);
		// two credits at reset, both used up here
		send_packet(s[0], x[0], y[0]);
		wait_count(CNT_PKT, base + 1, "packet 1");
		send_packet(s[1], x[1], y[1]);
		wait_count(CNT_PKT, base + 2, "packet 2");
		send_packet(s[2], x[2], y[2]);
		@(posedge clk);
		check_value("packet 3 held", 32'(base + 2), 32'(valid_cnt));
		// slot still full, so this one is lost
		send_packet(s[3], x[3], y[3]);
		wait_count(CNT_DROP, base_drop + 1, "packet_drop");
		@(posedge clk);
		check_value("held across drop", 32'(base + 2), 32'(valid_cnt));
		credit_req = 1;
		wait_count(CNT_PKT, base + 3, "packet 3 on credit");
		for (int i = 0; i < 3; i++)
			check_packet($sformatf("packet %0d", i + 1), expected_packet(s[i], x[i], y[i]));
		// hand back the rest, slot is empty now
		@(posedge clk);
		credit_req = 2;
		idle(HALF);
		@(posedge clk);
		check_value("no extra packet", 32'(base + 3), 32'(valid_cnt));
		check_value("drop count", 32'(base_drop + 1), 32'(drop_cnt));
		auto_credit = 1'b1;
		end_test();
	endtask

	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		reset = 1'b0;
		mouse_clk_low = 1'b0;
		mouse_data_low = 1'b0;
		lfsr = 32'hdbc3;
		test_init();
		test_resend();
		test_decode();
		test_errors();
		test_credits();
		$display("%0d tests run, %0d errors", test_cnt, error_cnt);
		if (error_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== dv/ps2_mouse_chk.sv ====
// PS/2 mouse host protocol checker
// credit flow, drop exclusivity and bus clock release in stream mode

`include "ps2_config.svh"

module ps2_mouse_chk (
	input logic clk,
	input logic reset,
	input logic packet_valid,
	input logic packet_credit,
	input logic packet_drop,
	input logic streaming,
	input logic hold_clk_low
);

	timeunit 1ns;
	timeprecision 100ps;

	// credits granted by the consumer and not yet spent
	logic [3:0] credits;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			credits <= 4'(`PS2_CREDITS);
		else
			credits <= credits + {3'b000, packet_credit} - {3'b000, packet_valid};
	end

	////////////////////////////////////////////////////////////////////////////
	// a packet needs a credit in hand, or one arriving as it is released
	a_credit: assert property (@(posedge clk) disable iff (!reset)
		packet_valid |-> (credits != 4'd0))
		else $error("packet_valid issued with no credit left");

	// a packet is either delivered or dropped, never both
	a_valid_drop: assert property (@(posedge clk) disable iff (!reset)
		!(packet_valid && packet_drop))
		else $error("packet_valid and packet_drop high together");

	// host lets go of the bus clock once streaming
	a_clk_free: assert property (@(posedge clk) disable iff (!reset)
		streaming |-> !hold_clk_low)
		else $error("bus clock held low while streaming");

endmodule

bind ps2_mouse_top ps2_mouse_chk i_chk (
	.clk           (clk),
	.reset         (reset),
	.packet_valid  (packet_valid),
	.packet_credit (packet_credit),
	.packet_drop   (packet_drop),
	.streaming     (streaming),
	.hold_clk_low  (hold_clk_low)
);

// ==== hdl/ps2_mouse_top.sv ====
// PS/2 mouse host interface, top level
// line interface, frame receiver and transmitter, init controller
// and packet assembler with credit flow control

module ps2_mouse_top (
	input  logic       clk,
	input  logic       reset,
	input  logic       packet_credit,
	inout  wire        ps2_clk,
	inout  wire        ps2_data,
	output logic       packet_valid,
	output logic       left,
	output logic       right,
	output logic       middle,
	output logic [8:0] dx,
	output logic [8:0] dy,
	output logic       streaming,
	output logic       frame_error,
	output logic       packet_drop
);

	import ps2_pkg::*;

	// line interface
	logic clk_fall;
	logic data_s;
	logic hold_clk_low;
	logic hold_data_low;
	// receive side
	logic rx_enable;
	logic rx_valid;
	rx_byte_t rx_byte;
	logic rx_parity_err;
	// transmit side
	logic tx_start;
	logic [7:0] tx_cmd;
	logic tx_done;
	logic tx_acked;
	logic stream_on;

	ps2_line_sync i_line_sync (
		.clk           (clk),
		.reset         (reset),
		.hold_clk_low  (hold_clk_low),
		.hold_data_low (hold_data_low),
		.ps2_clk       (ps2_clk),
		.ps2_data      (ps2_data),
		.clk_fall      (clk_fall),
		.data_s        (data_s)
	);

	ps2_frame_rx i_frame_rx (
		.clk           (clk),
		.reset         (reset),
		.clk_fall      (clk_fall),
		.data_s        (data_s),
		.rx_enable     (rx_enable),
		.rx_valid      (rx_valid),
		.rx_byte       (rx_byte),
		.rx_parity_err (rx_parity_err)
	);

	ps2_frame_tx i_frame_tx (
		.clk           (clk),
		.reset         (reset),
		.clk_fall      (clk_fall),
		.data_s        (data_s),
		.tx_start      (tx_start),
		.tx_cmd        (tx_cmd),
		.hold_data_low (hold_data_low),
		.tx_done       (tx_done),
		.tx_acked      (tx_acked)
	);

	ps2_mouse_ctrl i_mouse_ctrl (
		.clk           (clk),
		.reset         (reset),
		.tx_done       (tx_done),
		.tx_acked      (tx_acked),
		.rx_valid      (rx_valid),
		.rx_byte       (rx_byte),
		.rx_parity_err (rx_parity_err),
		.hold_clk_low  (hold_clk_low),
		.tx_start      (tx_start),
		.tx_cmd        (tx_cmd),
		.rx_enable     (rx_enable),
		.stream_on     (stream_on),
		.streaming     (streaming)
	);

	ps2_packet_asm i_packet_asm (
		.clk           (clk),
		.reset         (reset),
		.stream_on     (stream_on),
		.rx_valid      (rx_valid),
		.rx_byte       (rx_byte),
		.rx_parity_err (rx_parity_err),
		.packet_credit (packet_credit),
		.packet_valid  (packet_valid),
		.left          (left),
		.right         (right),
		.middle        (middle),
		.dx            (dx),
		.dy            (dy),
		.frame_error   (frame_error),
		.packet_drop   (packet_drop)
	);

endmodule

// ==== hdl/ps2_packet_asm.sv ====
// PS/2 movement packet assembler
// three bytes into buttons and 9-bit signed deltas, one hold slot,
// packets released against consumer credits

`include "ps2_config.svh"

module ps2_packet_asm (
	input  logic       clk,
	input  logic       reset,
	input  logic       stream_on,
	input  logic       rx_valid,
	input  ps2_pkg::rx_byte_t rx_byte,
	input  logic       rx_parity_err,
	input  logic       packet_credit,
	output logic       packet_valid,
	output logic       left,
	output logic       right,
	output logic       middle,
	output logic [8:0] dx,
	output logic [8:0] dy,
	output logic       frame_error,
	output logic       packet_drop
);

	import ps2_pkg::*;

	// next byte position in the packet
	logic [1:0] byte_cnt;
	// status and x of the packet being built
	rx_byte_t stat_q;
	logic [7:0] x_q;
	// hold slot
	rx_byte_t hold_stat;
	logic [7:0] hold_x;
	logic [7:0] hold_y;
	logic held;
	logic [2:0] credit_cnt;
	logic byte_ok;
	logic pkt_done;
	logic release_pkt;
	logic load_slot;

	assign byte_ok = stream_on && rx_valid && !rx_parity_err;
	assign pkt_done = byte_ok && (byte_cnt == 2'd2);
	// a credit arriving this cycle counts too
	assign release_pkt = held && ((credit_cnt != 3'd0) || packet_credit);
	// slot frees up the same cycle it is released
	assign load_slot = pkt_done && (!held || release_pkt);

	////////////////////////////////////////////////////////////////////////////
	// byte count, slot, credits
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			byte_cnt <= 2'd0;
			held <= 1'b0;
			credit_cnt <= 3'(`PS2_CREDITS);
			packet_valid <= 1'b0;
			frame_error <= 1'b0;
			packet_drop <= 1'b0;
		end
		else
		begin
			frame_error <= stream_on && rx_valid && rx_parity_err;
			packet_drop <= pkt_done && !load_slot;
			packet_valid <= release_pkt;
			credit_cnt <= credit_cnt + {2'b00, packet_credit} - {2'b00, release_pkt};
			// bad byte throws away the partial packet
			if (!stream_on || (rx_valid && rx_parity_err))
				byte_cnt <= 2'd0;
			else if (byte_ok)
			begin
				case (byte_cnt)
					// bit 3 clear means not a status byte, stay put to resync
					2'd0:
						if (rx_byte.status.always_one)
							byte_cnt <= 2'd1;
					2'd1:
						byte_cnt <= 2'd2;
					default:
						byte_cnt <= 2'd0;
				endcase
			end
			if (load_slot)
				held <= 1'b1;
			else if (release_pkt)
				held <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// packet data
	always_ff @(posedge clk)
	begin
		if (byte_ok && (byte_cnt == 2'd0))
			stat_q <= rx_byte;
		if (byte_ok && (byte_cnt == 2'd1))
			x_q <= rx_byte.code;
		if (load_slot)
		begin
			hold_stat <= stat_q;
			hold_x <= x_q;
			hold_y <= rx_byte.code;
		end
		// sign bits from the status byte become bit 8
		if (release_pkt)
		begin
			left <= hold_stat.status.left;
			right <= hold_stat.status.right;
			middle <= hold_stat.status.middle;
			dx <= {hold_stat.status.x_sign, hold_x};
			dy <= {hold_stat.status.y_sign, hold_y};
		end
	end

endmodule

// ==== hdl/ps2_mouse_ctrl.sv ====
// PS/2 mouse host controller
// inhibit, request to send, send 0xF4, wait for 0xFA, then stream
// any failure during init goes back to inhibit and starts over

`include "ps2_config.svh"

module ps2_mouse_ctrl (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_done,
	input  logic       tx_acked,
	input  logic       rx_valid,
	input  ps2_pkg::rx_byte_t rx_byte,
	input  logic       rx_parity_err,
	output logic       hold_clk_low,
	output logic       tx_start,
	output logic [7:0] tx_cmd,
	output logic       rx_enable,
	output logic       stream_on,
	output logic       streaming
);

	import ps2_pkg::*;

	// one timer covers all waits, sized for the longest
	localparam int TMR_W = $clog2(`PS2_ACK_TIMEOUT + 1);
	localparam logic [TMR_W-1:0] INHIBIT_LAST = TMR_W'(`PS2_INHIBIT_CYCLES - 1);
	localparam logic [TMR_W-1:0] RTS_LAST = TMR_W'(`PS2_RTS_CYCLES - 1);
	localparam logic [TMR_W-1:0] ACK_LAST = TMR_W'(`PS2_ACK_TIMEOUT - 1);

	ctrl_state_t state;
	ctrl_state_t state_next;
	// cycles spent in the current state
	logic [TMR_W-1:0] timer;
	logic timeout;

	assign timeout = (timer == ACK_LAST);

	////////////////////////////////////////////////////////////////////////////
	// next state
	always_comb
	begin
		state_next = state;
		case (state)
			INHIBIT:
				if (timer == INHIBIT_LAST)
					state_next = RTS;
			// start bit already on the line, clock still held
			RTS:
				if (timer == RTS_LAST)
					state_next = SEND;
			SEND:
			begin
				if (tx_done)
					state_next = tx_acked ? WAIT_ACK : INHIBIT;
				else if (timeout)
					state_next = INHIBIT;
			end
			WAIT_ACK:
			begin
				// resend or anything else restarts init
				if (rx_valid)
				begin
					if (!rx_parity_err && (rx_byte.code == PS2_RSP_ACK))
						state_next = STREAM;
					else
						state_next = INHIBIT;
				end
				else if (timeout)
					state_next = INHIBIT;
			end
			STREAM:
				state_next = STREAM;
			default:
				state_next = INHIBIT;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// state, timer and registered line controls
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= INHIBIT;
			timer <= '0;
			hold_clk_low <= 1'b0;
			tx_start <= 1'b0;
			rx_enable <= 1'b0;
			streaming <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// restart on every change, idle once streaming
			if ((state_next != state) || (state == STREAM))
				timer <= '0;
			else
				timer <= timer + 1'b1;
			// bus clock low through inhibit and request to send
			hold_clk_low <= (state_next == INHIBIT) || (state_next == RTS);
			// start bit goes out as the request to send begins
			tx_start <= (state == INHIBIT) && (state_next == RTS);
			rx_enable <= (state_next == WAIT_ACK) || (state_next == STREAM);
			streaming <= (state_next == STREAM);
		end
	end

	// only command ever sent
	assign tx_cmd = PS2_CMD_STREAM_ON;
	// gates packet bytes into the assembler
	assign stream_on = (state == STREAM);

endmodule

// ==== hdl/ps2_frame_tx.sv ====
// PS/2 host-to-device frame transmitter
// start bit on tx_start, then data LSB first, odd parity and stop,
// one bit per device clock fall; samples the line ack on the 11th fall

module ps2_frame_tx (
	input  logic       clk,
	input  logic       reset,
	input  logic       clk_fall,
	input  logic       data_s,
	input  logic       tx_start,
	input  logic [7:0] tx_cmd,
	output logic       hold_data_low,
	output logic       tx_done,
	output logic       tx_acked
);

	// frame in progress
	logic busy;
	// falls seen since start, 0 to 10
	logic [3:0] bit_cnt;
	// {parity, d7..d0}, bit 0 goes out next
	logic [8:0] shreg;
	logic tx_step;

	// a fresh start always wins over a leftover frame
	assign tx_step = busy && clk_fall && !tx_start;

	////////////////////////////////////////////////////////////////////////////
	// frame sequencing
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			busy <= 1'b0;
			bit_cnt <= 4'd0;
			hold_data_low <= 1'b0;
			tx_done <= 1'b0;
			tx_acked <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (tx_start)
			begin
				// start bit, goes out while the bus clock is still held
				busy <= 1'b1;
				bit_cnt <= 4'd0;
				hold_data_low <= 1'b1;
			end
			else if (tx_step)
			begin
				case (bit_cnt)
					4'd9:
					begin
						// release for the stop bit
						hold_data_low <= 1'b0;
						bit_cnt <= bit_cnt + 4'd1;
					end
					4'd10:
					begin
						// device pulls data low to acknowledge
						busy <= 1'b0;
						bit_cnt <= 4'd0;
						tx_done <= 1'b1;
						tx_acked <= ~data_s;
					end
					default:
					begin
						// d0..d7 then parity
						hold_data_low <= ~shreg[0];
						bit_cnt <= bit_cnt + 4'd1;
					end
				endcase
			end
		end
	end

	// command and parity, shifted out one bit per fall
	always_ff @(posedge clk)
	begin
		if (tx_start)
			shreg <= {~^tx_cmd, tx_cmd};
		else if (tx_step)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

// ==== hdl/ps2_frame_rx.sv ====
// PS/2 device-to-host frame receiver
// start, 8 data bits LSB first, odd parity, stop
// one rx_valid pulse per frame, bad framing reported as parity error

`include "ps2_config.svh"

module ps2_frame_rx (
	input  logic clk,
	input  logic reset,
	input  logic clk_fall,
	input  logic data_s,
	input  logic rx_enable,
	output logic rx_valid,
	output ps2_pkg::rx_byte_t rx_byte,
	output logic rx_parity_err
);

	localparam int WD_W = $clog2(`PS2_FRAME_TIMEOUT + 1);
	localparam logic [WD_W-1:0] WD_LAST = WD_W'(`PS2_FRAME_TIMEOUT - 1);

	// falls seen so far in this frame, 0 to 10
	logic [3:0] bit_cnt;
	// parity, d7..d0, start; start ends up in bit 0
	logic [9:0] shreg;
	// cycles since the last device clock fall
	logic [WD_W-1:0] wd_cnt;
	logic frame_end;
	logic wd_expire;

	// 11th fall is the stop bit, taken straight from the line
	assign frame_end = rx_enable && clk_fall && (bit_cnt == 4'd10);
	// only a partial frame can time out
	assign wd_expire = (bit_cnt != 4'd0) && (wd_cnt == WD_LAST);

	////////////////////////////////////////////////////////////////////////////
	// bit counter, watchdog, status
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bit_cnt <= 4'd0;
			wd_cnt <= '0;
			rx_valid <= 1'b0;
			rx_parity_err <= 1'b0;
		end
		else
		begin
			rx_valid <= frame_end;
			if (!rx_enable || wd_expire)
			begin
				// drop whatever was partly shifted in
				bit_cnt <= 4'd0;
				wd_cnt <= '0;
			end
			else if (clk_fall)
			begin
				bit_cnt <= frame_end ? 4'd0 : bit_cnt + 4'd1;
				wd_cnt <= '0;
			end
			else if (bit_cnt != 4'd0)
				wd_cnt <= wd_cnt + 1'b1;
			// start must be 0, stop 1, data plus parity odd
			if (frame_end)
				rx_parity_err <= shreg[0] | ~data_s | ~(^shreg[9:1]);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// shift register and byte out
	always_ff @(posedge clk)
	begin
		// new bit enters at the top, LSB first on the wire
		if (rx_enable && clk_fall && !frame_end)
			shreg <= {data_s, shreg[9:1]};
		if (frame_end)
			rx_byte.code <= shreg[8:1];
	end

endmodule

// ==== hdl/ps2_line_sync.sv ====
// PS/2 line interface
// synchronizes device clock and data, flags device clock falls
// and drives both bus lines open drain

`include "ps2_config.svh"

module ps2_line_sync (
	input  logic clk,
	input  logic reset,
	input  logic hold_clk_low,
	input  logic hold_data_low,
	inout  wire  ps2_clk,
	inout  wire  ps2_data,
	output logic clk_fall,
	output logic data_s
);

	localparam int STAGES = `PS2_SYNC_STAGES;

	// sync chains, bus idles high
	logic [STAGES-1:0] clk_sync;
	logic [STAGES-1:0] data_sync;
	// previous synchronized clock level
	logic clk_prev;

	// open drain, pull-up on the board gives the high level
	assign ps2_clk = hold_clk_low ? 1'b0 : 1'bz;
	assign ps2_data = hold_data_low ? 1'b0 : 1'bz;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			clk_sync <= '1;
			data_sync <= '1;
			clk_prev <= 1'b1;
		end
		else
		begin
			clk_sync <= {clk_sync[STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[STAGES-2:0], ps2_data};
			clk_prev <= clk_sync[STAGES-1];
		end
	end

	// high to low on the last stage, STAGES cycles after the bus edge
	assign clk_fall = clk_prev & ~clk_sync[STAGES-1];
	// same depth as the clock, so data lines up with the edge
	assign data_s = data_sync[STAGES-1];

endmodule

// ==== hdl/ps2_pkg.sv ====
// PS/2 mouse shared types
// controller states, protocol codes and the two views of a received byte

package ps2_pkg;

	// init and run states of the host controller
	typedef enum logic [2:0] {
		INHIBIT,
		RTS,
		SEND,
		WAIT_ACK,
		STREAM
	} ctrl_state_t;

	// enable data reporting
	localparam logic [7:0] PS2_CMD_STREAM_ON = 8'hF4;
	// device acknowledge
	localparam logic [7:0] PS2_RSP_ACK = 8'hFA;

	// first byte of a movement packet, MSB first
	typedef struct packed {
		logic y_ovf;
		logic x_ovf;
		logic y_sign;
		logic x_sign;
		logic always_one;
		logic middle;
		logic right;
		logic left;
	} status_t;

	// same byte seen as a response code during init, or as packet status
	typedef union packed {
		logic [7:0] code;
		status_t status;
	} rx_byte_t;

endpackage

// ==== hdl/ps2_config.svh ====
// PS/2 mouse host timing and flow-control constants
// all counts are in system clock cycles
// values are shortened for simulation; hardware values noted alongside

`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

// host holds the bus clock low before a request to send
// real hardware needs at least 100 us of inhibit
`define PS2_INHIBIT_CYCLES 200

// data pulled low, then clock held this long before release
// hardware: a few us is plenty
`define PS2_RTS_CYCLES 20

// no device clock edge for this long abandons a partial frame
// hardware: about 2 ms
`define PS2_FRAME_TIMEOUT 2000

// limit on waiting for line ack or the 0xFA reply
// hardware: tens of ms
`define PS2_ACK_TIMEOUT 20000

// consumer credits at reset, counter is 3 bits wide
`define PS2_CREDITS 2

// synchronizer depth on both bus lines, at least 2
`define PS2_SYNC_STAGES 3

`endif
